//--- design/pulse_hist_params.svh
`ifndef PULSE_HIST_PARAMS_SVH
`define PULSE_HIST_PARAMS_SVH

// Widths and depth shared by the histogram recorder.

// Bin number width with one bin per pulse height.
`define PH_ADDR_W 12

// Per-bin count width that wraps past all ones.
`define PH_CNT_W 16

// Acquisition window length in clock cycles.
`define PH_WIN_W 16

// One RAM word per bin.
`define PH_DEPTH 4096

`endif

//--- design/pulse_hist_types_pkg.sv
`default_nettype none

`include "pulse_hist_params.svh"

package pulse_hist_types_pkg;

    // Histogram bin number that doubles as the RAM address.
    typedef logic [`PH_ADDR_W-1:0] bin_addr_t;

    // Count held in one bin.
    typedef logic [`PH_CNT_W-1:0] count_t;

    // Window length in clock cycles.
    typedef logic [`PH_WIN_W-1:0] win_len_t;

endpackage

`default_nettype wire

//--- design/pulse_hist_ctrl_pkg.sv
`default_nettype none

package pulse_hist_ctrl_pkg;

    // Update FSM states.
    typedef enum logic [2:0] {
        UPD_IDLE,     // Waiting for an event or a host request.
        UPD_EVT_RD,   // Reading the bin count.
        UPD_EVT_WR,   // Writing the count plus one.
        UPD_EVT_ACK,  // Holding evt ack until req drops.
        UPD_HOST_RD,  // Reading the bin for the host.
        UPD_HOST_CLR, // Writing zero back.
        UPD_HOST_ACK  // Holding host ack until req drops.
    } upd_state_t;

    // RAM scheduler steps.
    typedef enum logic [1:0] {
        SCH_IDLE,   // No access in flight.
        SCH_ACCESS, // RAM addressed with the strobe high on writes.
        SCH_LATCH,  // Read data captured here.
        SCH_ACK     // Ack held through the release.
    } sched_step_t;

endpackage

`default_nettype wire

//--- design/block_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "pulse_hist_params.svh"

module block_ram
    import pulse_hist_types_pkg::*;
(
    input  logic      iClk,
    input  bin_addr_t addr_i,
    input  count_t    wdata_i,
    input  logic      we_i,
    output count_t    rdata_o   // Registered read-first output.
);

    count_t mem [`PH_DEPTH];    // One count per bin.

    initial
    begin
        for (int i = 0; i < `PH_DEPTH; i++)
        begin
            mem[i] = '0;        // Empty histogram at configuration.
        end
    end

    always @(posedge iClk)
    begin
        if (we_i)
        begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i]; // Old data on a same-address write.
    end

endmodule

`default_nettype wire

//--- design/bram_schedule.sv
`timescale 1ns/10ps
`default_nettype none

module bram_schedule
    import pulse_hist_types_pkg::*;
    import pulse_hist_ctrl_pkg::*;
(
    input  logic      iClk,
    input  logic      iRst_N,
    input  logic      wr_req_i,     // Four-phase write request.
    input  logic      rd_req_i,     // Four-phase read request.
    input  bin_addr_t addr_i,
    input  count_t    wdata_i,
    output logic      ack_o,
    output count_t    rdata_o,      // Valid while ack_o is high.
    output bin_addr_t ram_addr_o,
    output count_t    ram_wdata_o,
    output logic      ram_we_o,
    input  count_t    ram_rdata_i   // One cycle behind ram_addr_o.
);

    sched_step_t step_q;

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            step_q      <= SCH_IDLE;
            ram_addr_o  <= '0;
            ram_wdata_o <= '0;
            ram_we_o    <= 1'b0;
            rdata_o     <= '0;
            ack_o       <= 1'b0;
        end
        else
        begin
            case (step_q)
                SCH_IDLE:
                begin
                    if (wr_req_i || rd_req_i)
                    begin
                        ram_addr_o  <= addr_i;      // Drive address and data.
                        ram_wdata_o <= wdata_i;
                        ram_we_o    <= wr_req_i;    // Strobe only on writes.
                        step_q      <= SCH_ACCESS;
                    end
                end
                SCH_ACCESS:
                begin
                    ram_we_o <= 1'b0;               // One-cycle write strobe.
                    step_q   <= SCH_LATCH;          // Read data lands next cycle.
                end
                SCH_LATCH:
                begin
                    if (rd_req_i)
                    begin
                        rdata_o <= ram_rdata_i;     // Capture registered RAM output.
                    end
                    else
                    begin
                        ack_o <= 1'b1;              // Write is done already.
                    end
                    step_q <= SCH_ACK;
                end
                SCH_ACK:
                begin
                    if (!ack_o)
                    begin
                        ack_o <= 1'b1;              // Read ack one cycle after the latch.
                    end
                    else if (!wr_req_i && !rd_req_i)
                    begin
                        ack_o  <= 1'b0;             // Close handshake on release.
                        step_q <= SCH_IDLE;
                    end
                end
                default:
                begin
                    step_q <= SCH_IDLE;
                end
            endcase
        end
    end

    // The FSM issues one kind of access at a time.
    a_one_req: assert property (@(posedge iClk) disable iff (!iRst_N)
        !(wr_req_i && rd_req_i))
        else $error("bram_schedule: write and read requested together");

    // Ack drops only once the requester has released.
    a_ack_release: assert property (@(posedge iClk) disable iff (!iRst_N)
        $fell(ack_o) |-> $past(!wr_req_i && !rd_req_i))
        else $error("bram_schedule: ack fell while a request was high");

endmodule

`default_nettype wire

//--- design/acq_window_timer.sv
`timescale 1ns/10ps
`default_nettype none

module acq_window_timer
    import pulse_hist_types_pkg::*;
(
    input  logic     iClk,
    input  logic     iRst_N,
    input  logic     win_start_i,   // One-cycle start that also restarts an open window.
    input  win_len_t win_len_i,     // Sampled with win_start_i.
    output logic     win_open_o
);

    win_len_t remain_q;             // Cycles left in the window.

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            remain_q   <= '0;
            win_open_o <= 1'b0;
        end
        else if (win_start_i)
        begin
            remain_q   <= win_len_i;              // Load on start.
            win_open_o <= (win_len_i != '0);      // Zero length never opens.
        end
        else if (remain_q != '0)
        begin
            remain_q   <= remain_q - 1'b1;
            win_open_o <= (remain_q != win_len_t'(1)); // Last open cycle.
        end
    end

    // Output and counter agree at the window end.
    a_closed: assert property (@(posedge iClk) disable iff (!iRst_N)
        (remain_q == '0) |-> !win_open_o)
        else $error("acq_window_timer: window open with no cycles left");

endmodule

`default_nettype wire

//--- design/hist_update_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module hist_update_fsm
    import pulse_hist_types_pkg::*;
    import pulse_hist_ctrl_pkg::*;
(
    input  logic      iClk,
    input  logic      iRst_N,
    input  logic      evt_req_i,      // Four-phase pulse event.
    input  bin_addr_t evt_bin_i,
    output logic      evt_ack_o,
    input  logic      host_req_i,     // Four-phase host readout.
    input  bin_addr_t host_bin_i,
    input  logic      host_clr_i,     // Zero the bin after reading.
    output logic      host_ack_o,
    output count_t    host_count_o,   // Valid while host_ack_o is high.
    input  logic      win_open_i,
    output logic      sch_wr_req_o,
    output logic      sch_rd_req_o,
    output bin_addr_t sch_addr_o,
    output count_t    sch_wdata_o,
    input  logic      sch_ack_i,
    input  count_t    sch_rdata_i
);

    upd_state_t state_q;

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            state_q      <= UPD_IDLE;
            evt_ack_o    <= 1'b0;
            host_ack_o   <= 1'b0;
            host_count_o <= '0;
            sch_wr_req_o <= 1'b0;
            sch_rd_req_o <= 1'b0;
            sch_addr_o   <= '0;
            sch_wdata_o  <= '0;
        end
        else
        begin
            case (state_q)
                UPD_IDLE:
                begin
                    if (evt_req_i && win_open_i)
                    begin
                        sch_addr_o   <= evt_bin_i;       // Events win over the host.
                        sch_rd_req_o <= 1'b1;
                        state_q      <= UPD_EVT_RD;
                    end
                    else if (evt_req_i)
                    begin
                        evt_ack_o <= 1'b1;               // Closed window is not counted.
                        state_q   <= UPD_EVT_ACK;
                    end
                    else if (host_req_i)
                    begin
                        sch_addr_o   <= host_bin_i;
                        sch_rd_req_o <= 1'b1;
                        state_q      <= UPD_HOST_RD;
                    end
                end
                UPD_EVT_RD:
                begin
                    if (sch_rd_req_o && sch_ack_i)
                    begin
                        sch_rd_req_o <= 1'b0;
                        sch_wdata_o  <= sch_rdata_i + 1'b1; // Wraps at all ones.
                    end
                    else if (!sch_rd_req_o && !sch_ack_i)
                    begin
                        sch_wr_req_o <= 1'b1;            // Write back the new count.
                        state_q      <= UPD_EVT_WR;
                    end
                end
                UPD_EVT_WR:
                begin
                    if (sch_wr_req_o && sch_ack_i)
                    begin
                        sch_wr_req_o <= 1'b0;
                    end
                    else if (!sch_wr_req_o && !sch_ack_i)
                    begin
                        evt_ack_o <= 1'b1;               // Count stored.
                        state_q   <= UPD_EVT_ACK;
                    end
                end
                UPD_EVT_ACK:
                begin
                    if (!evt_req_i)
                    begin
                        evt_ack_o <= 1'b0;               // Held until the source releases.
                        state_q   <= UPD_IDLE;
                    end
                end
                UPD_HOST_RD:
                begin
                    if (sch_rd_req_o && sch_ack_i)
                    begin
                        sch_rd_req_o <= 1'b0;
                        host_count_o <= sch_rdata_i;     // Count for the host.
                    end
                    else if (!sch_rd_req_o && !sch_ack_i && host_clr_i)
                    begin
                        sch_wdata_o  <= '0;
                        sch_wr_req_o <= 1'b1;            // Clear after reading.
                        state_q      <= UPD_HOST_CLR;
                    end
                    else if (!sch_rd_req_o && !sch_ack_i)
                    begin
                        host_ack_o <= 1'b1;
                        state_q    <= UPD_HOST_ACK;
                    end
                end
                UPD_HOST_CLR:
                begin
                    if (sch_wr_req_o && sch_ack_i)
                    begin
                        sch_wr_req_o <= 1'b0;
                    end
                    else if (!sch_wr_req_o && !sch_ack_i)
                    begin
                        host_ack_o <= 1'b1;              // Bin is zero now.
                        state_q    <= UPD_HOST_ACK;
                    end
                end
                UPD_HOST_ACK:
                begin
                    if (!host_req_i)
                    begin
                        host_ack_o <= 1'b0;
                        state_q    <= UPD_IDLE;
                    end
                end
                default:
                begin
                    state_q <= UPD_IDLE;
                end
            endcase
        end
    end

    // Only one port is served at a time.
    a_one_ack: assert property (@(posedge iClk) disable iff (!iRst_N)
        !(evt_ack_o && host_ack_o))
        else $error("hist_update_fsm: event and host acks high together");

endmodule

`default_nettype wire

//--- design/pulse_hist_top.sv
`timescale 1ns/10ps
`default_nettype none

module pulse_hist_top
    import pulse_hist_types_pkg::*;
(
    input  logic      iClk,
    input  logic      iRst_N,
    input  logic      evt_req_i,     // Pulse port.
    input  bin_addr_t evt_bin_i,
    output logic      evt_ack_o,
    input  logic      host_req_i,    // Host port.
    input  bin_addr_t host_bin_i,
    input  logic      host_clr_i,
    output logic      host_ack_o,
    output count_t    host_count_o,
    input  logic      win_start_i,   // Window control.
    input  win_len_t  win_len_i,
    output logic      win_open_o
);

    logic      sch_wr_req;           // FSM to scheduler.
    logic      sch_rd_req;
    bin_addr_t sch_addr;
    count_t    sch_wdata;
    logic      sch_ack;
    count_t    sch_rdata;
    bin_addr_t ram_addr;             // Scheduler to RAM.
    count_t    ram_wdata;
    logic      ram_we;
    count_t    ram_rdata;

    acq_window_timer acq_window_timer_i (
        .iClk        (iClk),
        .iRst_N      (iRst_N),
        .win_start_i (win_start_i),
        .win_len_i   (win_len_i),
        .win_open_o  (win_open_o)
    );

    hist_update_fsm hist_update_fsm_i (
        .iClk         (iClk),
        .iRst_N       (iRst_N),
        .evt_req_i    (evt_req_i),
        .evt_bin_i    (evt_bin_i),
        .evt_ack_o    (evt_ack_o),
        .host_req_i   (host_req_i),
        .host_bin_i   (host_bin_i),
        .host_clr_i   (host_clr_i),
        .host_ack_o   (host_ack_o),
        .host_count_o (host_count_o),
        .win_open_i   (win_open_o),
        .sch_wr_req_o (sch_wr_req),
        .sch_rd_req_o (sch_rd_req),
        .sch_addr_o   (sch_addr),
        .sch_wdata_o  (sch_wdata),
        .sch_ack_i    (sch_ack),
        .sch_rdata_i  (sch_rdata)
    );

    bram_schedule bram_schedule_i (
        .iClk        (iClk),
        .iRst_N      (iRst_N),
        .wr_req_i    (sch_wr_req),
        .rd_req_i    (sch_rd_req),
        .addr_i      (sch_addr),
        .wdata_i     (sch_wdata),
        .ack_o       (sch_ack),
        .rdata_o     (sch_rdata),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_we_o    (ram_we),
        .ram_rdata_i (ram_rdata)
    );

    block_ram block_ram_i (
        .iClk    (iClk),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .we_i    (ram_we),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/pulse_hist_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pulse_hist_params.svh"

module pulse_hist_tb
    import pulse_hist_types_pkg::*;
();

    localparam int ACK_TIMEOUT = 200;           // Cycles per handshake phase.
    localparam int RUN_LIMIT   = 100000;        // Whole-run watchdog.

    logic      iClk;
    logic      iRst_N;
    logic      evt_req;
    bin_addr_t evt_bin;
    logic      evt_ack;
    logic      host_req;
    bin_addr_t host_bin;
    logic      host_clr;
    logic      host_ack;
    count_t    host_count;
    logic      win_start;
    win_len_t  win_len;
    logic      win_open;

    count_t model_cnt [`PH_DEPTH];              // Expected count per bin.
    int     edge_cnt = 0;                       // Rising edges seen so far.
    int     win_start_edge;                     // Edge that drove the last start.
    int     win_len_m;                          // Length of the last window.
    integer seed = 32'hf625_e380;
    int     fd;
    int     code;
    int     need;
    int     n_cmds;
    int     a;
    int     b;
    int     c;
    string  cmd;
    string  rest;
    string  name;

    pulse_hist_top pulse_hist_top_i (
        .iClk         (iClk),
        .iRst_N       (iRst_N),
        .evt_req_i    (evt_req),
        .evt_bin_i    (evt_bin),
        .evt_ack_o    (evt_ack),
        .host_req_i   (host_req),
        .host_bin_i   (host_bin),
        .host_clr_i   (host_clr),
        .host_ack_o   (host_ack),
        .host_count_o (host_count),
        .win_start_i  (win_start),
        .win_len_i    (win_len),
        .win_open_o   (win_open)
    );

    always #20 iClk = ~iClk;                    // 40 ns period.

    always @(posedge iClk)
    begin
        edge_cnt <= edge_cnt + 1;
    end

    // Open after edges start+1 through start+len.
    function automatic bit open_after(int k);
        return (win_len_m != 0) && (k >= win_start_edge + 1)
            && (k <= win_start_edge + win_len_m);
    endfunction

    task automatic check_count(string tname, count_t exp, count_t act);
        if (act !== exp)
        begin
            $display("Error %s: expected %0d, actual %0d", tname, exp, act);
            $display("TB FAILED");
            $fatal(1, "Bin count differs from the expected value.");
        end
    endtask

    task automatic check_open(string tname, logic exp, logic act);
        if (act !== exp)
        begin
            $display("Error %s: expected %b, actual %b", tname, exp, act);
            $display("TB FAILED");
            $fatal(1, "Window state differs from the expected value.");
        end
    endtask

    // Sampled on the falling edge away from DUT updates.
    task automatic wait_ack(bit from_host, logic level, string tname);
        int waited;
        waited = 0;
        @(negedge iClk);
        while ((from_host ? host_ack : evt_ack) !== level)
        begin
            if (waited >= ACK_TIMEOUT)
            begin
                $display("TB FAILED");
                $fatal(1, "%s: ack never went to %b, the handshake is stuck.", tname, level);
            end
            waited++;
            @(negedge iClk);
        end
    endtask

    task automatic idle_random();
        int n;
        n = $unsigned($random(seed)) % 4;       // Zero to three idle cycles.
        repeat (n) @(posedge iClk);
    endtask

    task automatic start_window(int len);
        @(posedge iClk);
        win_len        <= win_len_t'(len);
        win_start      <= 1'b1;
        win_start_edge = edge_cnt + 1;          // Edge just passed.
        win_len_m      = len;
        @(posedge iClk);
        win_start <= 1'b0;                      // One-cycle pulse.
    endtask

    task automatic send_event(bin_addr_t bin, string tname);
        int drive_edge;
        idle_random();
        @(posedge iClk);
        evt_bin    <= bin;
        evt_req    <= 1'b1;
        drive_edge = edge_cnt + 1;
        wait_ack(1'b0, 1'b1, tname);
        @(posedge iClk);
        evt_req <= 1'b0;                        // Release.
        wait_ack(1'b0, 1'b0, tname);
        if (open_after(drive_edge))
        begin
            model_cnt[bin] = model_cnt[bin] + 1'b1; // Wraps like a 16-bit counter.
        end
    endtask

    task automatic host_read(bin_addr_t bin, logic clr, count_t exp, string tname);
        count_t got;
        idle_random();
        @(posedge iClk);
        host_bin <= bin;
        host_clr <= clr;
        host_req <= 1'b1;
        wait_ack(1'b1, 1'b1, tname);
        got = host_count;                       // Valid while ack is high.
        check_count(tname, exp, got);
        check_count({tname, " model"}, model_cnt[bin], got);
        @(posedge iClk);
        host_req <= 1'b0;
        wait_ack(1'b1, 1'b0, tname);
        if (clr)
        begin
            model_cnt[bin] = '0;
        end
    endtask

    task automatic expect_window(int cycles, logic exp, string tname);
        repeat (cycles) @(posedge iClk);
        @(negedge iClk);
        check_open(tname, exp, win_open);
        check_open({tname, " model"}, open_after(edge_cnt), win_open);
    endtask

    initial
    begin
        repeat (RUN_LIMIT) @(posedge iClk);
        $display("TB FAILED");
        $fatal(1, "The run did not finish within %0d cycles.", RUN_LIMIT);
    end

    initial
    begin
        iClk           = 1'b0;
        iRst_N         = 1'b0;
        evt_req        = 1'b0;
        evt_bin        = '0;
        host_req       = 1'b0;
        host_bin       = '0;
        host_clr       = 1'b0;
        win_start      = 1'b0;
        win_len        = '0;
        win_start_edge = 0;
        win_len_m      = 0;                     // No window yet.
        n_cmds         = 0;
        for (int i = 0; i < `PH_DEPTH; i++)
        begin
            model_cnt[i] = '0;
        end
        repeat (8) @(posedge iClk);
        iRst_N <= 1'b1;
        fd = $fopen("testbench/pulse_hist_tests.txt", "r");
        if (fd == 0)
        begin
            $display("TB FAILED");
            $fatal(1, "The test file could not be opened.");
        end
        while ($fscanf(fd, " %s", cmd) == 1)
        begin
            if (cmd.substr(0, 0) == "#")
            begin
                code = $fgets(rest, fd);        // Skip the comment line.
                continue;
            end
            case (cmd)
                "W", "E":
                begin
                    code = $fscanf(fd, " %d", a);
                    need = 1;
                end
                "R":
                begin
                    code = $fscanf(fd, " %d %d %d", a, b, c);
                    need = 3;
                end
                "C":
                begin
                    code = $fscanf(fd, " %d %d", a, b);
                    need = 2;
                end
                default:
                begin
                    $display("TB FAILED");
                    $fatal(1, "Unknown command %s in the test file.", cmd);
                end
            endcase
            if (code != need)
            begin
                $display("TB FAILED");
                $fatal(1, "Fields are missing after command %s.", cmd);
            end
            name = $sformatf("#%0d %s %0d", n_cmds, cmd, a);
            case (cmd)
                "W": start_window(a);
                "E": send_event(bin_addr_t'(a), name);
                "R": host_read(bin_addr_t'(a), b[0], count_t'(c), name);
                "C": expect_window(a, b[0], name);
                default: ;
            endcase
            n_cmds++;
        end
        $fclose(fd);
        if (n_cmds > 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            $display("TB FAILED");
            $fatal(1, "The test file held no commands.");
        end
    end

endmodule

`default_nettype wire

//--- testbench/pulse_hist_tests.txt
# Columns: W len | E bin | R bin clr expected | C cycles expected_open
# Decimal fields. R checks the count read back, C waits cycles then checks win_open.
C 2 0
R 0 0 0
R 4095 0 0
R 100 0 0
W 3000
C 4 1
E 5
E 5
E 5
E 7
R 5 0 3
R 6 0 0
R 7 0 1
E 10
R 5 0 3
E 4095
R 7 0 1
E 10
R 4095 0 1
E 5
R 10 0 2
C 3000 0
E 5
E 20
R 5 0 4
R 20 0 0
R 5 1 4
R 5 0 0
R 10 1 2
R 10 0 0

//--- sources.f
+incdir+design
design/pulse_hist_types_pkg.sv
design/pulse_hist_ctrl_pkg.sv
design/block_ram.sv
design/bram_schedule.sv
design/acq_window_timer.sv
design/hist_update_fsm.sv
design/pulse_hist_top.sv
testbench/pulse_hist_tb.sv

//--- Bender.yml
package:
  name: pulse_hist

sources:
  - include_dirs:
      - design
    files:
      - design/pulse_hist_types_pkg.sv
      - design/pulse_hist_ctrl_pkg.sv
      - design/block_ram.sv
      - design/bram_schedule.sv
      - design/acq_window_timer.sv
      - design/hist_update_fsm.sv
      - design/pulse_hist_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/pulse_hist_tb.sv
